// ==== design/edge_buffer_pkg.sv ====
`default_nettype none

package edge_buffer_pkg;

    // one bank per edge processing element
    localparam int NUM_BANKS = 4;
    localparam int FIFO_DEPTH = 4;

    // one feature value, two of them travel per entry
    localparam int FV_WIDTH = 16;
    localparam int SRAM_ADDR_WIDTH = 8;

    localparam int BANK_ID_WIDTH = $clog2(NUM_BANKS);
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    typedef logic [2*FV_WIDTH-1:0] fv_pair_t;
    typedef logic [NUM_BANKS-1:0] bank_sel_t;
    typedef logic [BANK_ID_WIDTH-1:0] bank_id_t;
    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;
    typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;

    // one extra bit so a full FIFO can be told apart from an empty one
    typedef logic [FIFO_PTR_WIDTH:0] fifo_cnt_t;

    // head dispatcher of a bank
    typedef enum logic [1:0] {
        HEAD_IDLE,
        HEAD_RS,
        HEAD_SRAM
    } bank_state_t;

endpackage

`default_nettype wire

// ==== design/edge_buffer_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module edge_buffer_bank (
    input  logic                       clk,
    input  logic                       reset,

    // from the edge processing element
    input  logic                       edge_valid,
    input  logic                       edge_sos,
    input  logic                       edge_eos,
    input  logic                       edge_wb,
    input  edge_buffer_pkg::fv_pair_t  edge_data,

    // grants from the arbiter and the output SRAM
    input  logic                       rs_grant,
    input  logic                       req_grant,

    // reservation-station side
    output logic                       rs_req,
    output logic                       rs_sos,
    output logic                       rs_eos,
    output edge_buffer_pkg::fv_pair_t  rs_data,

    // output-SRAM side
    output logic                       sram_req,
    output edge_buffer_pkg::sram_addr_t sram_addr,
    output logic                       sram_eos,
    output edge_buffer_pkg::fv_pair_t  sram_data,

    output logic                       bank_busy
);

    import edge_buffer_pkg::*;

    // entry storage, flags kept next to the payload
    fv_pair_t               fifo_data [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0]  fifo_sos;
    logic [FIFO_DEPTH-1:0]  fifo_eos;
    logic [FIFO_DEPTH-1:0]  fifo_wb;

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_cnt_t   count;

    bank_state_t state;
    bank_state_t state_next;

    sram_addr_t  wb_index;

    logic        fifo_full;
    logic        fifo_empty;
    logic        push;
    logic        pop;
    logic        rs_pop;
    logic        sram_xfer;

    logic        head_sos;
    logic        head_eos;
    logic        head_wb;
    fv_pair_t    head_data;

    assign fifo_full  = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);

    // strobes into a full bank are lost
    assign push = edge_valid && !fifo_full;

    assign rs_pop    = (state == HEAD_RS) && rs_grant;
    assign sram_xfer = sram_req && req_grant;
    assign pop       = rs_pop || sram_xfer;

    assign head_sos  = fifo_sos[rd_ptr];
    assign head_eos  = fifo_eos[rd_ptr];
    assign head_wb   = fifo_wb[rd_ptr];
    assign head_data = fifo_data[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_data[wr_ptr] <= edge_data;
            fifo_sos[wr_ptr]  <= edge_sos;
            fifo_eos[wr_ptr]  <= edge_eos;
            fifo_wb[wr_ptr]   <= edge_wb;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head dispatcher
    // goes back to idle after every pop so the new head is looked at afresh
    always_comb begin
        state_next = state;
        case (state)
            HEAD_IDLE: begin
                if (!fifo_empty) begin
                    state_next = head_wb ? HEAD_SRAM : HEAD_RS;
                end
            end
            HEAD_RS: begin
                if (rs_grant) begin
                    state_next = HEAD_IDLE;
                end
            end
            HEAD_SRAM: begin
                if (req_grant) begin
                    state_next = HEAD_IDLE;
                end
            end
            default: state_next = HEAD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= HEAD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // write-back numbering within a stream
    // an sos entry restarts the count whichever path it takes
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wb_index <= '0;
        end else if (pop) begin
            if (head_sos) begin
                wb_index <= sram_xfer ? sram_addr_t'(1) : '0;
            end else if (sram_xfer) begin
                wb_index <= wb_index + 1'b1;
            end
        end
    end

    // request withdrawn in the grant cycle, the entry is already leaving
    assign rs_req  = (state == HEAD_RS) && !rs_grant;
    assign rs_sos  = head_sos;
    assign rs_eos  = head_eos;
    assign rs_data = head_data;

    // level request, held until the SRAM grants it
    assign sram_req  = (state == HEAD_SRAM);
    assign sram_addr = head_sos ? '0 : wb_index;
    assign sram_eos  = head_eos;
    assign sram_data = head_data;

    assign bank_busy = fifo_full;

endmodule

`default_nettype wire

// ==== design/round_robin_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module round_robin_arbiter (
    input  logic                       clk,
    input  logic                       reset,
    input  edge_buffer_pkg::bank_sel_t req,
    input  logic                       rs_busy,
    output edge_buffer_pkg::bank_sel_t grant
);

    import edge_buffer_pkg::*;

    bank_sel_t rotate_mask;
    bank_sel_t masked_req;
    bank_sel_t masked_pick;
    bank_sel_t plain_pick;
    bank_sel_t pick;
    bank_sel_t next_mask;

    // lowest set bit wins, bank 0 first
    function automatic bank_sel_t lowest_first(input bank_sel_t r);
        return r & bank_sel_t'(~r + 1'b1);
    endfunction

    assign masked_req  = req & rotate_mask;
    assign masked_pick = lowest_first(masked_req);
    assign plain_pick  = lowest_first(req);

    // nothing left above the last winner, so wrap to the full request set
    assign pick = (masked_req != '0) ? masked_pick : plain_pick;

    // banks strictly above the winner
    always_comb begin
        logic seen;
        seen = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            next_mask[b] = seen;
            seen = seen | pick[b];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            grant       <= '0;
            rotate_mask <= '1;
        end else begin
            grant <= rs_busy ? '0 : pick;
            // rotate only when a grant really goes out
            if (!rs_busy && (pick != '0)) begin
                rotate_mask <= next_mask;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/edge_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module edge_buffer (
    input  logic                                                  clk,
    input  logic                                                  reset,

    // edge processing elements, one bit or word per bank
    input  edge_buffer_pkg::bank_sel_t                            edge_valid,
    input  edge_buffer_pkg::bank_sel_t                            edge_sos,
    input  edge_buffer_pkg::bank_sel_t                            edge_eos,
    input  edge_buffer_pkg::bank_sel_t                            edge_wb,
    input  edge_buffer_pkg::fv_pair_t [edge_buffer_pkg::NUM_BANKS-1:0] edge_data,

    input  edge_buffer_pkg::bank_sel_t                            req_grant,
    input  logic                                                  rs_busy,

    // shared reservation-station port
    output logic                                                  rs_valid,
    output edge_buffer_pkg::bank_id_t                             rs_bank,
    output logic                                                  rs_sos,
    output logic                                                  rs_eos,
    output edge_buffer_pkg::fv_pair_t                             rs_data,

    // per-bank write-back requests
    output edge_buffer_pkg::bank_sel_t                            sram_req,
    output edge_buffer_pkg::sram_addr_t [edge_buffer_pkg::NUM_BANKS-1:0] sram_addr,
    output edge_buffer_pkg::bank_sel_t                            sram_eos,
    output edge_buffer_pkg::fv_pair_t [edge_buffer_pkg::NUM_BANKS-1:0] sram_data,

    output logic                                                  busy
);

    import edge_buffer_pkg::*;

    bank_sel_t                   rs_req;
    bank_sel_t                   rs_grant;
    bank_sel_t                   bank_busy;
    bank_sel_t                   bank_rs_sos;
    bank_sel_t                   bank_rs_eos;
    fv_pair_t [NUM_BANKS-1:0]    bank_rs_data;

    for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
        edge_buffer_bank bank_i (
            .clk        (clk),
            .reset      (reset),
            .edge_valid (edge_valid[i]),
            .edge_sos   (edge_sos[i]),
            .edge_eos   (edge_eos[i]),
            .edge_wb    (edge_wb[i]),
            .edge_data  (edge_data[i]),
            .rs_grant   (rs_grant[i]),
            .req_grant  (req_grant[i]),
            .rs_req     (rs_req[i]),
            .rs_sos     (bank_rs_sos[i]),
            .rs_eos     (bank_rs_eos[i]),
            .rs_data    (bank_rs_data[i]),
            .sram_req   (sram_req[i]),
            .sram_addr  (sram_addr[i]),
            .sram_eos   (sram_eos[i]),
            .sram_data  (sram_data[i]),
            .bank_busy  (bank_busy[i])
        );
    end

    round_robin_arbiter rr_arb_i (
        .clk     (clk),
        .reset   (reset),
        .req     (rs_req),
        .rs_busy (rs_busy),
        .grant   (rs_grant)
    );

    // any full bank stalls the processing elements
    assign busy = |bank_busy;

    // grant is one-hot, zeros go out when no bank holds it
    always_comb begin
        rs_valid = 1'b0;
        rs_bank  = '0;
        rs_sos   = 1'b0;
        rs_eos   = 1'b0;
        rs_data  = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (rs_grant[b]) begin
                rs_valid = 1'b1;
                rs_bank  = bank_id_t'(b);
                rs_sos   = bank_rs_sos[b];
                rs_eos   = bank_rs_eos[b];
                rs_data  = bank_rs_data[b];
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/edge_buffer_tb_table.svh ====
`ifndef EDGE_BUFFER_TB_TABLE_SVH
`define EDGE_BUFFER_TB_TABLE_SVH

// columns: test, bank (-1 idle), sos, eos, wb, data, rs_busy, sram grant delay
localparam int TABLE_ROWS = 23;

row_t table_rows [TABLE_ROWS] = '{
    // single station entry into bank 2
    '{1, 2, 1'b1, 1'b1, 1'b0, 32'h1111_2222, 1'b0, 0},
    // stream into bank 0, eos on the last entry
    '{2, 0, 1'b1, 1'b0, 1'b0, 32'h2000_0001, 1'b0, 0},
    '{2, 0, 1'b0, 1'b0, 1'b0, 32'h2000_0002, 1'b0, 0},
    '{2, 0, 1'b0, 1'b0, 1'b0, 32'h2000_0003, 1'b0, 0},
    '{2, 0, 1'b0, 1'b1, 1'b0, 32'h2000_0004, 1'b0, 0},
    // all banks loaded behind a busy station
    '{3, 0, 1'b1, 1'b0, 1'b0, 32'h3000_0000, 1'b1, 0},
    '{3, 1, 1'b1, 1'b0, 1'b0, 32'h3000_0001, 1'b1, 0},
    '{3, 2, 1'b1, 1'b0, 1'b0, 32'h3000_0002, 1'b1, 0},
    '{3, 3, 1'b1, 1'b0, 1'b0, 32'h3000_0003, 1'b1, 0},
    '{3, 0, 1'b0, 1'b1, 1'b0, 32'h3000_0010, 1'b1, 0},
    '{3, 1, 1'b0, 1'b1, 1'b0, 32'h3000_0011, 1'b1, 0},
    '{3, 2, 1'b0, 1'b1, 1'b0, 32'h3000_0012, 1'b1, 0},
    '{3, 3, 1'b0, 1'b1, 1'b0, 32'h3000_0013, 1'b1, 0},
    // two write-back streams into bank 1
    '{4, 1, 1'b1, 1'b0, 1'b1, 32'h4000_00a0, 1'b0, 2},
    '{4, 1, 1'b0, 1'b0, 1'b1, 32'h4000_00a1, 1'b0, 0},
    '{4, 1, 1'b0, 1'b1, 1'b1, 32'h4000_00a2, 1'b0, 3},
    '{4, 1, 1'b1, 1'b0, 1'b1, 32'h4000_00b0, 1'b0, 1},
    '{4, 1, 1'b0, 1'b1, 1'b1, 32'h4000_00b1, 1'b0, 4},
    // bank 3 filled, the fifth strobe is lost
    '{5, 3, 1'b1, 1'b0, 1'b0, 32'h5000_0001, 1'b1, 0},
    '{5, 3, 1'b0, 1'b0, 1'b0, 32'h5000_0002, 1'b1, 0},
    '{5, 3, 1'b0, 1'b0, 1'b0, 32'h5000_0003, 1'b1, 0},
    '{5, 3, 1'b0, 1'b1, 1'b0, 32'h5000_0004, 1'b1, 0},
    '{5, 3, 1'b0, 1'b1, 1'b0, 32'h5000_00ff, 1'b1, 0}
};

`endif

// ==== sim/edge_buffer_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module edge_buffer_tb;

    import edge_buffer_pkg::*;

    typedef struct packed {
        int       test;
        int       bank;
        logic     sos;
        logic     eos;
        logic     wb;
        fv_pair_t data;
        logic     busy;
        int       delay;
    } row_t;

    `include "edge_buffer_tb_table.svh"

    localparam int STRESS_ROWS = 48;

    logic                        clk;
    logic                        reset;
    bank_sel_t                   edge_valid;
    bank_sel_t                   edge_sos;
    bank_sel_t                   edge_eos;
    bank_sel_t                   edge_wb;
    fv_pair_t [NUM_BANKS-1:0]    edge_data;
    bank_sel_t                   req_grant;
    logic                        rs_busy;
    logic                        rs_valid;
    bank_id_t                    rs_bank;
    logic                        rs_sos;
    logic                        rs_eos;
    fv_pair_t                    rs_data;
    bank_sel_t                   sram_req;
    sram_addr_t [NUM_BANKS-1:0]  sram_addr;
    bank_sel_t                   sram_eos;
    fv_pair_t [NUM_BANKS-1:0]    sram_data;
    logic                        busy;

    // expected traffic per bank: {sos, eos, data} and {addr, eos, data}
    logic [33:0]  rs_exp [NUM_BANKS][$];
    int           rs_cyc [NUM_BANKS][$];
    logic [40:0]  sram_exp [NUM_BANKS][$];
    int           grant_delay [NUM_BANKS][$];
    int           occ [NUM_BANKS];
    int           wait_cnt [NUM_BANKS];
    sram_addr_t   wb_cnt [NUM_BANKS];
    int           bank_seq [$];
    row_t         rows [$];

    logic [31:0]  lcg_state = 32'h45a;
    int           cycle = 0;
    int           cur_test = 0;
    logic         prev_busy = 1'b0;
    bank_sel_t    sram_waiting = '0;
    // first bank of the round-robin search, reset priority at the start
    int           rr_next = 0;
    int           rr_start = 0;
    int           test_errors = 0;
    int           total_errors = 0;
    int           failed_tests = 0;
    int           tests_run = 0;

    edge_buffer edge_buffer_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cycle++;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic queues_pending();
        logic p;
        p = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            p = p | (rs_exp[b].size() != 0) | (sram_exp[b].size() != 0);
        end
        return p;
    endfunction

    task automatic value_error(input string sig, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("error at %0t: %s is %h, expected %h", $time, sig, got, exp);
        test_errors++;
    endtask

    // busy is high exactly while some bank holds FIFO_DEPTH entries
    task automatic check_busy();
        logic exp_busy;
        exp_busy = 1'b0;
        for (int k = 0; k < NUM_BANKS; k++) begin
            exp_busy = exp_busy | (occ[k] == FIFO_DEPTH);
        end
        assert (busy == exp_busy) else value_error("busy", 64'(busy), 64'(exp_busy));
    endtask

    task automatic clear_inputs();
        edge_valid = '0;
        edge_sos   = '0;
        edge_eos   = '0;
        edge_wb    = '0;
        edge_data  = '0;
    endtask

    // drive one row and record what the buffer should emit for it
    task automatic apply_row(input row_t r);
        int   b;
        check_busy();
        clear_inputs();
        rs_busy = r.busy;
        b = r.bank;
        if (b >= 0) begin
            edge_valid[b] = 1'b1;
            edge_sos[b]   = r.sos;
            edge_eos[b]   = r.eos;
            edge_wb[b]    = r.wb;
            edge_data[b]  = r.data;
            // a full bank drops the strobe
            if (occ[b] < FIFO_DEPTH) begin
                occ[b]++;
                if (r.sos) begin
                    wb_cnt[b] = '0;
                end
                if (r.wb) begin
                    sram_exp[b].push_back({wb_cnt[b], r.eos, r.data});
                    grant_delay[b].push_back(r.delay);
                    wb_cnt[b] = wb_cnt[b] + sram_addr_t'(1);
                end else begin
                    rs_exp[b].push_back({r.sos, r.eos, r.data});
                    rs_cyc[b].push_back(cycle);
                end
            end
        end
    endtask

    task automatic drain_and_report(input int test);
        int waited;
        int exp_bank;
        clear_inputs();
        rs_busy = 1'b0;
        waited = 0;
        while (queues_pending() && waited < 300) begin
            @(posedge clk);
            #2;
            check_busy();
            waited++;
        end
        if (queues_pending()) begin
            $display("test %0d: expected outputs still missing after 300 cycles", test);
            test_errors++;
        end
        // idle window to catch stray outputs
        repeat (6) @(posedge clk);
        #2;
        if (test == 3) begin
            assert (bank_seq.size() == 8) else begin
                $display("test 3: %0d station packets seen instead of 8", bank_seq.size());
                test_errors++;
            end
            // rotation starts after the last winner of the previous test
            for (int i = 0; i < bank_seq.size() && i < 8; i++) begin
                exp_bank = (rr_start + i) % NUM_BANKS;
                assert (bank_seq[i] == exp_bank)
                    else value_error("rs_bank", 64'(bank_seq[i]), 64'(exp_bank));
            end
        end
        tests_run++;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %0d: %s, %0d errors", test, (test_errors == 0) ? "pass" : "fail",
                 test_errors);
        total_errors += test_errors;
        test_errors = 0;
        rr_start = rr_next;
    endtask

    // SRAM side answers each request after the delay of its entry
    always @(posedge clk) begin
        #2;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (req_grant[b]) begin
                req_grant[b] = 1'b0;
            end else if (sram_req[b]) begin
                if (grant_delay[b].size() == 0 || wait_cnt[b] >= grant_delay[b][0]) begin
                    req_grant[b] = 1'b1;
                    wait_cnt[b]  = 0;
                    if (grant_delay[b].size() != 0) begin
                        void'(grant_delay[b].pop_front());
                    end
                end else begin
                    wait_cnt[b]++;
                end
            end
        end
    end

    // outputs are checked mid-cycle, away from every edge
    always @(negedge clk) begin : monitor
        logic [33:0] re;
        logic [40:0] se;
        int          b;
        int          cyc;
        if (reset) begin
            assert (!(rs_valid && prev_busy)) else begin
                $display("rs_valid rose at %0t after a cycle with rs_busy high", $time);
                test_errors++;
            end
            if (rs_valid) begin
                b = int'(rs_bank);
                if (cur_test == 3) begin
                    bank_seq.push_back(b);
                end
                if (rs_exp[b].size() == 0) begin
                    $display("unexpected station packet from bank %0d at %0t", b, $time);
                    test_errors++;
                end else begin
                    re  = rs_exp[b].pop_front();
                    cyc = rs_cyc[b].pop_front();
                    occ[b]--;
                    // search resumes at the bank after the winner
                    rr_next = (b + 1) % NUM_BANKS;
                    assert (rs_data == re[31:0])
                        else value_error("rs_data", 64'(rs_data), 64'(re[31:0]));
                    assert (rs_sos == re[33]) else value_error("rs_sos", 64'(rs_sos), 64'(re[33]));
                    assert (rs_eos == re[32]) else value_error("rs_eos", 64'(rs_eos), 64'(re[32]));
                    if (cur_test == 1) begin
                        assert (cycle - cyc == 3)
                            else value_error("rs_valid latency", 64'(cycle - cyc), 64'(3));
                    end
                end
            end
            for (int k = 0; k < NUM_BANKS; k++) begin
                // a write-back request stays up until it is granted
                assert (!sram_waiting[k] || sram_req[k]) else begin
                    $display("sram_req of bank %0d dropped at %0t before its grant", k, $time);
                    test_errors++;
                end
                sram_waiting[k] = sram_req[k] && !req_grant[k];
                if (sram_req[k] && req_grant[k]) begin
                    if (sram_exp[k].size() == 0) begin
                        $display("unexpected write-back from bank %0d at %0t", k, $time);
                        test_errors++;
                    end else begin
                        se = sram_exp[k].pop_front();
                        occ[k]--;
                        assert (sram_addr[k] == se[40:33])
                            else value_error("sram_addr", 64'(sram_addr[k]), 64'(se[40:33]));
                        assert (sram_eos[k] == se[32])
                            else value_error("sram_eos", 64'(sram_eos[k]), 64'(se[32]));
                        assert (sram_data[k] == se[31:0])
                            else value_error("sram_data", 64'(sram_data[k]), 64'(se[31:0]));
                    end
                end
            end
        end
        prev_busy = rs_busy;
    end

    initial begin
        row_t        r;
        logic [31:0] x;
        clk       = 1'b0;
        reset     = 1'b0;
        rs_busy   = 1'b0;
        req_grant = '0;
        clear_inputs();
        for (int b = 0; b < NUM_BANKS; b++) begin
            occ[b]      = 0;
            wait_cnt[b] = 0;
            wb_cnt[b]   = '0;
        end
        for (int i = 0; i < TABLE_ROWS; i++) begin
            rows.push_back(table_rows[i]);
        end
        // random mix for the stress test
        for (int i = 0; i < STRESS_ROWS; i++) begin
            x       = next_rand();
            r.test  = 6;
            r.bank  = (x[20:18] == 3'd0) ? -1 : int'(x[17:16]);
            r.sos   = x[21];
            r.eos   = x[22];
            r.wb    = x[23];
            r.busy  = (x[25:24] == 2'd0);
            r.delay = int'(x[29:27]);
            r.data  = next_rand();
            rows.push_back(r);
        end
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b1;
        @(posedge clk);
        #2;
        for (int i = 0; i < rows.size(); i++) begin
            cur_test = rows[i].test;
            apply_row(rows[i]);
            @(posedge clk);
            #2;
            if (i == rows.size() - 1 || rows[i + 1].test != cur_test) begin
                drain_and_report(cur_test);
            end
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, failed_tests,
                 total_errors);
        if (failed_tests == 0 && total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== gnn_edge_buffer.f ====
+incdir+sim
design/edge_buffer_pkg.sv
design/edge_buffer_bank.sv
design/round_robin_arbiter.sv
design/edge_buffer.sv
sim/edge_buffer_tb.sv

// ==== Makefile ====
SIM := obj_dir/edge_buffer_sim

SOURCES := design/edge_buffer_pkg.sv design/edge_buffer_bank.sv \
           design/round_robin_arbiter.sv design/edge_buffer.sv \
           sim/edge_buffer_tb.sv sim/edge_buffer_tb_table.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) gnn_edge_buffer.f
	verilator --binary --timing --assert --top-module edge_buffer_tb \
		-f gnn_edge_buffer.f -o edge_buffer_sim

run: $(SIM)
	@output="$$(./$(SIM))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
